// ==== all.f ====
+incdir+include
verilog/oramPkg.sv
verilog/oramUserIf.sv
verilog/dramReqIf.sv
verilog/trafficGen.sv
verilog/oramCore.sv
verilog/dramBackend.sv
verilog/oramAsicWrap.sv
verification/dramModel.sv
verification/oramAsicWrap_checker.sv
verification/oramAsicWrap_tb.sv

// ==== verification/oramAsicWrap_tb.sv ====
/*
 * Testbench of the block memory controller wrapper
 * Directed tests of user traffic, traffic generator and dummy mode
 */
`timescale 1ns/1ps
`include "oram_config_config.svh"

module oramAsicWrap_tb;
	import oramPkg::*;

	localparam int HALF_PERIOD  = 50;
	localparam int RESET_CYCLES = 8;
	localparam int NUM_BLOCKS   = 1 << `ORAM_U;
	localparam logic [31:0] SEED = 32'h90a9_0681;
	// Cycle budget of each test, the watchdog gets their sum
	localparam int BUDGET_FULL    = 4000;
	localparam int BUDGET_MASKED  = 4000;
	localparam int BUDGET_STALL   = 6000;
	localparam int BUDGET_TGEN    = 12000;
	localparam int BUDGET_TGENERR = 12000;
	localparam int BUDGET_DUMMY   = 2000;
	localparam int WATCHDOG_CYCLES = BUDGET_FULL + BUDGET_MASKED + BUDGET_STALL
		+ BUDGET_TGEN + BUDGET_TGENERR + BUDGET_DUMMY;

	// --------------------
	// DUT ports
	logic                    Clock;
	logic                    arstN;
	logic                    modeTrafficGen;
	logic                    modeDummyGen;
	oramCmd_t                cmd;
	logic [`ORAM_U-1:0]      pAddr;
	logic [`DM_WIDTH-1:0]    wMask;
	logic                    cmdValid;
	logic                    cmdReady;
	logic [`FED_WIDTH-1:0]   dataIn;
	logic                    dataInValid;
	logic                    dataInReady;
	logic [`FED_WIDTH-1:0]   dataOut;
	logic                    dataOutValid;
	logic                    dataOutReady;
	dramCmd_t                dramCommand;
	logic [`DDRA_WIDTH-1:0]  dramAddress;
	logic                    dramCommandValid;
	logic                    dramCommandReady;
	logic [`BED_WIDTH-1:0]   dramReadData;
	logic                    dramReadDataValid;
	logic [`BED_WIDTH-1:0]   dramWriteData;
	logic [`DDRM_WIDTH-1:0]  dramWriteMask;
	logic                    dramWriteDataValid;
	logic                    dramWriteDataReady;
	logic                    tgenDone;
	logic                    tgenError;

	// Expected contents of user blocks
	logic [`FED_WIDTH-1:0]   refMem [0:NUM_BLOCKS-1];
	logic [`FED_WIDTH-1:0]   snapMem [0:NUM_BLOCKS-1];
	dramCmd_t                cmdLog [$];
	int                      errorCount = 0;
	int                      errorsAtStart = 0;
	int                      testsRun = 0;
	int                      testsFailed = 0;
	string                   currentTest = "reset";

	always #HALF_PERIOD Clock = ~Clock;

	oramAsicWrap u_oramAsicWrap (.*);

	dramModel u_dramModel (.*);

	bind oramAsicWrap oramAsicWrap_checker u_checker (.*);

	// Every accepted DRAM command
	always @(negedge Clock) begin
		if (arstN && dramCommandValid && dramCommandReady)
			cmdLog.push_back(dramCommand);
	end

	// --------------------
	// Reference rules
	function automatic logic [`DDRA_WIDTH-1:0] blockLocation(input logic [`ORAM_U-1:0] addr);
		return `DRAM_BASE + `DDRA_WIDTH'(addr);
	endfunction

	// Enough address copies to cover the word, then salted
	function automatic logic [`FED_WIDTH-1:0] expectedPattern(input logic [`ORAM_U-1:0] addr);
		logic [3*`ORAM_U-1:0] repeated;
		repeated = {3{addr}};
		return repeated[`FED_WIDTH-1:0] ^ `TGEN_SALT;
	endfunction

	function automatic logic [`FED_WIDTH-1:0] mergeBytes(
		input logic [`FED_WIDTH-1:0] oldWord,
		input logic [`FED_WIDTH-1:0] newWord,
		input logic [`DM_WIDTH-1:0]  mask
	);
		logic [`FED_WIDTH-1:0] res;
		for (int b = 0; b < `DM_WIDTH; b++) begin
			res[8*b +: 8] = mask[b] ? newWord[8*b +: 8] : oldWord[8*b +: 8];
		end
		return res;
	endfunction

	// --------------------
	// Compare tasks
	task automatic checkData(input string name, input logic [`FED_WIDTH-1:0] expected,
		input logic [`FED_WIDTH-1:0] actual);
		if (actual !== expected) begin
			errorCount++;
			$display("[ERROR] %0t ns %s expected %h actual %h", $time, name, expected, actual);
		end
	endtask

	task automatic checkCmd(input string name, input dramCmd_t expected, input dramCmd_t actual);
		if (actual !== expected) begin
			errorCount++;
			$display("[ERROR] %0t ns %s expected %s actual %s", $time, name,
				expected.name(), actual.name());
		end
	endtask

	task automatic checkFlag(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			errorCount++;
			$display("[ERROR] %0t ns %s expected %b actual %b", $time, name, expected, actual);
		end
	endtask

	task automatic startTest(input string name);
		currentTest   = name;
		errorsAtStart = errorCount;
	endtask

	task automatic finishTest();
		testsRun++;
		if (errorCount != errorsAtStart) begin
			testsFailed++;
			$display("%s: failed with %0d errors", currentTest, errorCount - errorsAtStart);
		end else begin
			$display("%s: passed", currentTest);
		end
	endtask

	// --------------------
	// User bus operations
	task automatic writeBlock(input logic [`ORAM_U-1:0] addr, input logic [`FED_WIDTH-1:0] data,
		input logic [`DM_WIDTH-1:0] mask);
		logic cmdDone;
		logic dataDone;
		logic cmdTake;
		logic dataTake;
		cmdDone  = 1'b0;
		dataDone = 1'b0;
		@(posedge Clock);
		#1;
		cmd         = CMD_WRITE;
		pAddr       = addr;
		wMask       = mask;
		dataIn      = data;
		cmdValid    = 1'b1;
		dataInValid = 1'b1;
		// Command and beat may go in either order
		while (!(cmdDone && dataDone)) begin
			@(negedge Clock);
			cmdTake  = cmdValid & cmdReady;
			dataTake = dataInValid & dataInReady;
			@(posedge Clock);
			#1;
			if (cmdTake) begin
				cmdDone  = 1'b1;
				cmdValid = 1'b0;
			end
			if (dataTake) begin
				dataDone    = 1'b1;
				dataInValid = 1'b0;
			end
		end
		// Done once the core takes commands again
		@(negedge Clock);
		while (!cmdReady)
			@(negedge Clock);
	endtask

	task automatic readBlock(input logic [`ORAM_U-1:0] addr, input logic stall,
		output logic [`FED_WIDTH-1:0] data);
		logic [`FED_WIDTH-1:0] held;
		logic                  seen;
		logic                  taken;
		@(posedge Clock);
		#1;
		cmd          = CMD_READ;
		pAddr        = addr;
		cmdValid     = 1'b1;
		dataOutReady = !stall;
		taken        = 1'b0;
		while (!taken) begin
			@(negedge Clock);
			taken = cmdValid & cmdReady;
			@(posedge Clock);
			#1;
		end
		cmdValid = 1'b0;
		seen     = 1'b0;
		taken    = 1'b0;
		while (!taken) begin
			@(negedge Clock);
			if (dataOutValid) begin
				// Block must not move while it waits
				if (seen)
					checkData("dataOut while stalled", held, dataOut);
				held  = dataOut;
				seen  = 1'b1;
				taken = dataOutReady;
			end
			@(posedge Clock);
			#1;
			if (stall)
				dataOutReady = ($urandom % 3) == 0;
		end
		dataOutReady = 1'b0;
		data         = held;
	endtask

	task automatic waitTgenDone();
		@(negedge Clock);
		while (!tgenDone)
			@(negedge Clock);
	endtask

	// --------------------
	// Directed tests
	task automatic testFullWrites();
		logic [`ORAM_U-1:0]    addrs [16];
		logic [`FED_WIDTH-1:0] data;
		startTest("test 1 full-mask writes");
		for (int i = 0; i < 16; i++) begin
			addrs[i] = `ORAM_U'($urandom);
			data     = $urandom;
			refMem[addrs[i]] = data;
			writeBlock(addrs[i], data, '1);
			checkData($sformatf("dram[%h]", blockLocation(addrs[i])), data,
				u_dramModel.mem[blockLocation(addrs[i])]);
		end
		for (int i = 0; i < 16; i++) begin
			readBlock(addrs[i], 1'b0, data);
			checkData("dataOut", refMem[addrs[i]], data);
		end
		finishTest();
	endtask

	task automatic testMaskedWrites();
		logic [`ORAM_U-1:0]    addr;
		logic [`FED_WIDTH-1:0] data;
		logic [`DM_WIDTH-1:0]  mask;
		startTest("test 2 masked writes");
		for (int blk = 0; blk < 4; blk++) begin
			addr = `ORAM_U'($urandom);
			data = $urandom;
			refMem[addr] = data;
			writeBlock(addr, data, '1);
			for (int k = 0; k < 4; k++) begin
				mask = `DM_WIDTH'($urandom);
				data = $urandom;
				refMem[addr] = mergeBytes(refMem[addr], data, mask);
				writeBlock(addr, data, mask);
				readBlock(addr, 1'b0, data);
				checkData($sformatf("masked read-back mask %b", mask), refMem[addr], data);
			end
		end
		finishTest();
	endtask

	task automatic testBackPressure();
		logic [`ORAM_U-1:0]    addrs [8];
		logic [`FED_WIDTH-1:0] data;
		startTest("test 3 read back-pressure");
		for (int i = 0; i < 8; i++) begin
			addrs[i] = `ORAM_U'($urandom);
			data     = $urandom;
			refMem[addrs[i]] = data;
			writeBlock(addrs[i], data, '1);
		end
		// Reads stalled, rewrites in between
		for (int round = 0; round < 2; round++) begin
			for (int i = 0; i < 8; i++) begin
				readBlock(addrs[i], 1'b1, data);
				checkData("dataOut under stall", refMem[addrs[i]], data);
				data = $urandom;
				refMem[addrs[i]] = data;
				writeBlock(addrs[i], data, '1);
			end
		end
		finishTest();
	endtask

	task automatic testTrafficGen();
		startTest("test 4 traffic generator");
		@(posedge Clock);
		#1;
		modeTrafficGen = 1'b1;
		waitTgenDone();
		checkFlag("tgenError", 1'b0, tgenError);
		@(posedge Clock);
		#1;
		modeTrafficGen = 1'b0;
		for (int i = 0; i < `TGEN_COUNT; i++) begin
			checkData($sformatf("dram[%h]", blockLocation(i)), expectedPattern(i),
				u_dramModel.mem[blockLocation(i)]);
		end
		finishTest();
	endtask

	task automatic testTrafficError();
		startTest("test 5 traffic error detection");
		@(posedge Clock);
		#1;
		modeTrafficGen = 1'b1;
		// First read marks the start of the read phase
		@(negedge Clock);
		while (!(dramCommandValid && dramCommandReady && dramCommand == DRAM_RD))
			@(negedge Clock);
		u_dramModel.corruptWord(blockLocation(`TGEN_COUNT - 1));
		waitTgenDone();
		checkFlag("tgenError", 1'b1, tgenError);
		@(posedge Clock);
		#1;
		modeTrafficGen = 1'b0;
		finishTest();
	endtask

	task automatic testDummyMode();
		logic [`BED_WIDTH-1:0] dummyBefore;
		int                    failsBefore;
		int                    quiet;
		startTest("test 6 dummy mode");
		dummyBefore = u_dramModel.mem[`DUMMY_ADDR];
		for (int i = 0; i < NUM_BLOCKS; i++) begin
			snapMem[i] = u_dramModel.mem[blockLocation(i)];
		end
		failsBefore = u_oramAsicWrap.u_checker.assertFails;
		cmdLog.delete();
		@(posedge Clock);
		#1;
		modeDummyGen = 1'b1;
		repeat (200) @(posedge Clock);
		#1;
		modeDummyGen = 1'b0;
		// Last pair drains
		quiet = 0;
		while (quiet < 12) begin
			@(negedge Clock);
			quiet = (dramCommandValid || dramWriteDataValid) ? 0 : quiet + 1;
		end
		$display("dummy commands accepted: %0d", cmdLog.size());
		checkFlag("dummy commands seen", 1'b1, cmdLog.size() > 0);
		checkFlag("dummy pairs complete", 1'b1, (cmdLog.size() % 2) == 0);
		foreach (cmdLog[i]) begin
			checkCmd($sformatf("dummy command %0d", i), (i % 2 == 0) ? DRAM_RD : DRAM_WR,
				cmdLog[i]);
		end
		checkData("dram[DUMMY_ADDR]", dummyBefore, u_dramModel.mem[`DUMMY_ADDR]);
		for (int i = 0; i < NUM_BLOCKS; i++) begin
			checkData($sformatf("dram[%h]", blockLocation(i)), snapMem[i],
				u_dramModel.mem[blockLocation(i)]);
		end
		checkFlag("dummy assertion failures", 1'b0,
			u_oramAsicWrap.u_checker.assertFails != failsBefore);
		finishTest();
	endtask

	// --------------------
	// Main sequence
	initial begin
		void'($urandom(SEED));
		Clock          = 1'b0;
		arstN          = 1'b0;
		modeTrafficGen = 1'b0;
		modeDummyGen   = 1'b0;
		cmd            = CMD_READ;
		pAddr          = '0;
		wMask          = '0;
		cmdValid       = 1'b0;
		dataIn         = '0;
		dataInValid    = 1'b0;
		dataOutReady   = 1'b0;
		repeat (RESET_CYCLES) @(posedge Clock);
		#1;
		arstN = 1'b1;
		testFullWrites();
		testMaskedWrites();
		testBackPressure();
		testTrafficGen();
		testTrafficError();
		testDummyMode();
		$display("tests run %0d, tests failed %0d, errors %0d, assertion failures %0d",
			testsRun, testsFailed, errorCount, u_oramAsicWrap.u_checker.assertFails);
		if (testsFailed == 0 && errorCount == 0 && u_oramAsicWrap.u_checker.assertFails == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

	// Watchdog over the summed budgets
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge Clock);
		$display("watchdog: %s still running after %0d cycles", currentTest, WATCHDOG_CYCLES);
		$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== verification/oramAsicWrap_checker.sv ====
/*
 * Port assertions of the wrapper, bound into the top level
 */
`timescale 1ns/1ps
`include "oram_config_config.svh"

module oramAsicWrap_checker (
	input logic                    Clock,
	input logic                    arstN,
	input logic                    modeTrafficGen,
	input logic                    modeDummyGen,
	input logic                    cmdReady,
	input logic                    dataOutValid,
	input oramPkg::dramCmd_t       dramCommand,
	input logic [`DDRA_WIDTH-1:0]  dramAddress,
	input logic                    dramCommandValid,
	input logic                    dramCommandReady
);

	// Failure count, read by the testbench at the end
	int assertFails = 0;

	// --------------------
	// DRAM command held under back-pressure
	property cmdHeld;
		@(posedge Clock) disable iff (!arstN)
		dramCommandValid && !dramCommandReady |=>
			dramCommandValid && $stable(dramCommand) && $stable(dramAddress);
	endproperty

	cmdHeldA: assert property (cmdHeld)
	else begin
		assertFails++;
		$error("DRAM command dropped or changed before ready");
	end

	// User side quiet in traffic mode
	property userQuiet;
		@(posedge Clock) disable iff (!arstN)
		modeTrafficGen |-> !cmdReady && !dataOutValid;
	endproperty

	userQuietA: assert property (userQuiet)
	else begin
		assertFails++;
		$error("user ready or valid high in traffic mode");
	end

	// Dummy traffic stays on one address
	property dummyAddr;
		@(posedge Clock) disable iff (!arstN)
		modeDummyGen && dramCommandValid && dramCommandReady |-> dramAddress == `DUMMY_ADDR;
	endproperty

	dummyAddrA: assert property (dummyAddr)
	else begin
		assertFails++;
		$error("dummy command to address %h", dramAddress);
	end

endmodule

// ==== verification/dramModel.sv ====
/*
 * Behavioral DRAM for the wrapper testbench
 * Random ready stalls, fixed read delay, single word corruption
 */
`timescale 1ns/1ps
`include "oram_config_config.svh"

module dramModel (
	input  logic                    Clock,
	input  logic                    arstN,
	input  oramPkg::dramCmd_t       dramCommand,
	input  logic [`DDRA_WIDTH-1:0]  dramAddress,
	input  logic                    dramCommandValid,
	output logic                    dramCommandReady,
	output logic [`BED_WIDTH-1:0]   dramReadData,
	output logic                    dramReadDataValid,
	input  logic [`BED_WIDTH-1:0]   dramWriteData,
	input  logic [`DDRM_WIDTH-1:0]  dramWriteMask,
	input  logic                    dramWriteDataValid,
	output logic                    dramWriteDataReady
);
	import oramPkg::*;

	// Cycles from command accept to read data sampled
	localparam int READ_DELAY = 4;
	localparam int WORDS      = 1 << `DDRA_WIDTH;

	logic [`BED_WIDTH-1:0]   mem [0:WORDS-1];
	// Addresses of accepted writes still waiting for their beat
	logic [`DDRA_WIDTH-1:0]  wrAddrQ [$];
	logic [`BED_WIDTH-1:0]   rdHold;
	int                      rdCount;

	// Values seen at the falling edge
	logic                    cmdAcc;
	logic                    beatAcc;
	dramCmd_t                cmdS;
	logic [`DDRA_WIDTH-1:0]  addrS;
	logic [`BED_WIDTH-1:0]   wDataS;
	logic [`DDRM_WIDTH-1:0]  wMaskS;

	// Flip a few bits of one stored word
	task automatic corruptWord(input logic [`DDRA_WIDTH-1:0] addr);
		mem[addr] = mem[addr] ^ 32'h8000_0101;
	endtask

	initial begin
		// Fill depends on every address bit
		for (int a = 0; a < WORDS; a++) begin
			mem[a] = {a[15:0] ^ 16'h5A5A, ~a[15:0]};
		end
		dramCommandReady   = 1'b0;
		dramWriteDataReady = 1'b0;
		dramReadDataValid  = 1'b0;
		dramReadData       = '0;
		rdCount            = 0;
	end

	// --------------------
	// Sample on the falling edge, update just after the rising edge
	always begin
		@(negedge Clock);
		cmdAcc  = dramCommandValid & dramCommandReady;
		beatAcc = dramWriteDataValid & dramWriteDataReady;
		cmdS    = dramCommand;
		addrS   = dramAddress;
		wDataS  = dramWriteData;
		wMaskS  = dramWriteMask;
		@(posedge Clock);
		#1;
		if (!arstN) begin
			dramCommandReady   = 1'b0;
			dramWriteDataReady = 1'b0;
			dramReadDataValid  = 1'b0;
			rdCount            = 0;
			wrAddrQ.delete();
		end else begin
			// Read return, one cycle pulse
			dramReadDataValid = 1'b0;
			if (rdCount > 0) begin
				rdCount--;
				if (rdCount == 0) begin
					dramReadDataValid = 1'b1;
					dramReadData      = rdHold;
				end
			end
			// Beat of the oldest accepted write
			if (beatAcc && wrAddrQ.size() > 0) begin
				for (int b = 0; b < `DDRM_WIDTH; b++) begin
					if (wMaskS[b])
						mem[wrAddrQ[0]][8*b +: 8] = wDataS[8*b +: 8];
				end
				void'(wrAddrQ.pop_front());
			end
			if (cmdAcc) begin
				if (cmdS == DRAM_WR) begin
					wrAddrQ.push_back(addrS);
				end else begin
					rdHold  = mem[addrS];
					rdCount = READ_DELAY - 1;
				end
			end
			// Random stalls, ready about three cycles in four
			dramCommandReady   = ($urandom % 4) != 0;
			dramWriteDataReady = ($urandom % 4) != 0;
		end
	end

endmodule

// ==== verilog/oramAsicWrap.sv ====
/*
 * Tapeout wrapper of the block memory controller
 * Adds a pattern traffic generator and a dummy DRAM access mode
 */
`timescale 1ns/1ps
`include "oram_config_config.svh"

module oramAsicWrap (
	input  logic                     Clock,
	input  logic                     arstN,
	input  logic                     modeTrafficGen,
	input  logic                     modeDummyGen,

	input  oramPkg::oramCmd_t        cmd,
	input  logic [`ORAM_U-1:0]       pAddr,
	input  logic [`DM_WIDTH-1:0]     wMask,
	input  logic                     cmdValid,
	output logic                     cmdReady,

	input  logic [`FED_WIDTH-1:0]    dataIn,
	input  logic                     dataInValid,
	output logic                     dataInReady,

	output logic [`FED_WIDTH-1:0]    dataOut,
	output logic                     dataOutValid,
	input  logic                     dataOutReady,

	output oramPkg::dramCmd_t        dramCommand,
	output logic [`DDRA_WIDTH-1:0]   dramAddress,
	output logic                     dramCommandValid,
	input  logic                     dramCommandReady,

	input  logic [`BED_WIDTH-1:0]    dramReadData,
	input  logic                     dramReadDataValid,

	output logic [`BED_WIDTH-1:0]    dramWriteData,
	output logic [`DDRM_WIDTH-1:0]   dramWriteMask,
	output logic                     dramWriteDataValid,
	input  logic                     dramWriteDataReady,

	output logic                     tgenDone,
	output logic                     tgenError
);

	oramUserIf tgenBus ();
	oramUserIf coreBus ();
	dramReqIf  dramBus ();

	// --------------------
	// Pattern source, runs only in traffic mode
	trafficGen u_trafficGen (
		.Clock  (Clock),
		.arstN  (arstN),
		.enable (modeTrafficGen),
		.bus    (tgenBus),
		.done   (tgenDone),
		.error  (tgenError)
	);

	// --------------------
	// Core input select
	assign coreBus.cmd          = modeTrafficGen ? tgenBus.cmd         : cmd;
	assign coreBus.pAddr        = modeTrafficGen ? tgenBus.pAddr       : pAddr;
	// Generator always writes whole blocks
	assign coreBus.wMask        = modeTrafficGen ? tgenBus.wMask       : wMask;
	assign coreBus.cmdValid     = modeTrafficGen ? tgenBus.cmdValid    : cmdValid;
	assign coreBus.dataIn       = modeTrafficGen ? tgenBus.dataIn      : dataIn;
	assign coreBus.dataInValid  = modeTrafficGen ? tgenBus.dataInValid : dataInValid;
	assign coreBus.dataOutReady = modeTrafficGen ? tgenBus.dataOutReady : dataOutReady;

	// Unselected side sees no ready and no valid
	assign tgenBus.cmdReady     = modeTrafficGen & coreBus.cmdReady;
	assign tgenBus.dataInReady  = modeTrafficGen & coreBus.dataInReady;
	assign tgenBus.dataOutValid = modeTrafficGen & coreBus.dataOutValid;
	assign cmdReady             = ~modeTrafficGen & coreBus.cmdReady;
	assign dataInReady          = ~modeTrafficGen & coreBus.dataInReady;
	assign dataOutValid         = ~modeTrafficGen & coreBus.dataOutValid;

	// Read data goes to both, valid decides
	assign tgenBus.dataOut = coreBus.dataOut;
	assign dataOut         = coreBus.dataOut;

	// --------------------
	// Controller and DRAM side
	oramCore u_oramCore (
		.Clock     (Clock),
		.arstN     (arstN),
		.dummyMode (modeDummyGen),
		.user      (coreBus),
		.dram      (dramBus)
	);

	dramBackend u_dramBackend (
		.Clock              (Clock),
		.arstN              (arstN),
		.dummyMode          (modeDummyGen),
		.req                (dramBus),
		.dramCommand        (dramCommand),
		.dramAddress        (dramAddress),
		.dramCommandValid   (dramCommandValid),
		.dramCommandReady   (dramCommandReady),
		.dramReadData       (dramReadData),
		.dramReadDataValid  (dramReadDataValid),
		.dramWriteData      (dramWriteData),
		.dramWriteMask      (dramWriteMask),
		.dramWriteDataValid (dramWriteDataValid),
		.dramWriteDataReady (dramWriteDataReady)
	);

endmodule

// ==== verilog/dramBackend.sv ====
/*
 * DRAM backend, issues command and write beat, returns read data
 * Runs dummy read/write pairs on one address for power runs
 */
`timescale 1ns/1ps
`include "oram_config_config.svh"

module dramBackend (
	input  logic                    Clock,
	input  logic                    arstN,
	input  logic                    dummyMode,
	dramReqIf.back                  req,

	output oramPkg::dramCmd_t       dramCommand,
	output logic [`DDRA_WIDTH-1:0]  dramAddress,
	output logic                    dramCommandValid,
	input  logic                    dramCommandReady,

	input  logic [`BED_WIDTH-1:0]   dramReadData,
	input  logic                    dramReadDataValid,

	output logic [`BED_WIDTH-1:0]   dramWriteData,
	output logic [`DDRM_WIDTH-1:0]  dramWriteMask,
	output logic                    dramWriteDataValid,
	input  logic                    dramWriteDataReady
);
	import oramPkg::*;

	typedef enum logic [1:0] {
		B_IDLE,
		B_CMD,
		B_WDATA,
		B_RWAIT
	} backState_t;

	backState_t               state;
	// Current access belongs to the dummy loop
	logic                     dummyR;

	dramCmd_t                 cmdR;
	logic [`DDRA_WIDTH-1:0]   addrR;
	logic [`BED_WIDTH-1:0]    wDataR;
	logic [`DDRM_WIDTH-1:0]   wMaskR;

	// --------------------
	// Port drive
	assign req.reqReady       = (state == B_IDLE);
	assign dramCommand        = cmdR;
	assign dramAddress        = addrR;
	assign dramCommandValid   = (state == B_CMD);
	assign dramWriteData      = wDataR;
	assign dramWriteMask      = wMaskR;
	assign dramWriteDataValid = (state == B_WDATA);

	// Dummy reads stay inside
	assign req.rspData  = dramReadData;
	assign req.rspValid = (state == B_RWAIT) & dramReadDataValid & ~dummyR;

	// --------------------
	// Issue sequence
	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			state  <= B_IDLE;
			dummyR <= 1'b0;
		end else begin
			case (state)
				B_IDLE: begin
					// Core request wins over dummy traffic
					if (req.reqValid) begin
						state  <= B_CMD;
						dummyR <= 1'b0;
					end else if (dummyMode) begin
						state  <= B_CMD;
						dummyR <= 1'b1;
					end
				end
				B_CMD:
					if (dramCommandReady)
						state <= (cmdR == DRAM_WR) ? B_WDATA : B_RWAIT;
				B_WDATA:
					if (dramWriteDataReady)
						state <= B_IDLE;
				B_RWAIT:
					// Dummy read always followed by its write back
					if (dramReadDataValid)
						state <= dummyR ? B_CMD : B_IDLE;
				default:
					state <= B_IDLE;
			endcase
		end
	end

	// Command and beat registers
	always_ff @(posedge Clock) begin
		if (state == B_IDLE) begin
			if (req.reqValid) begin
				cmdR   <= req.reqCmd;
				addrR  <= req.reqAddr;
				wDataR <= req.reqWData;
				wMaskR <= req.reqWMask;
			end else if (dummyMode) begin
				cmdR  <= DRAM_RD;
				addrR <= `DUMMY_ADDR;
			end
		end else if ((state == B_RWAIT) && dramReadDataValid && dummyR) begin
			// Same data back, memory unchanged
			cmdR   <= DRAM_WR;
			wDataR <= dramReadData;
			wMaskR <= {`DDRM_WIDTH{1'b1}};
		end
	end

endmodule

// ==== verilog/oramCore.sv ====
/*
 * Block memory controller core, one command in flight
 * Partial byte mask writes become read-modify-write
 */
`timescale 1ns/1ps
`include "oram_config_config.svh"

module oramCore (
	input  logic     Clock,
	input  logic     arstN,
	input  logic     dummyMode,
	oramUserIf.slave user,
	dramReqIf.core   dram
);
	import oramPkg::*;

	typedef enum logic [2:0] {
		S_IDLE,
		S_COLLECT,
		S_RDMERGE,
		S_WRITE,
		S_RETURN
	} coreState_t;

	coreState_t              state;
	coreState_t              nextState;
	// Ready flag, high only in idle
	logic                    rdyR;
	logic                    haveData;
	// DRAM request of this state handed over
	logic                    sent;

	oramCmd_t                cmdR;
	logic [`ORAM_U-1:0]      addrR;
	logic [`DM_WIDTH-1:0]    maskR;
	logic [`FED_WIDTH-1:0]   wDataR;
	logic [`FED_WIDTH-1:0]   blockR;
	logic [`FED_WIDTH-1:0]   merged;

	logic                    cmdAcc;
	logic                    dataAcc;
	logic                    reqAcc;

	// --------------------
	// User side handshakes
	assign user.cmdReady     = rdyR & ~dummyMode;
	// Data may come before or after its command
	assign user.dataInReady  = ~haveData & ((rdyR & ~dummyMode) | (state == S_COLLECT));
	assign user.dataOutValid = (state == S_RETURN);
	assign user.dataOut      = blockR;

	assign cmdAcc  = user.cmdValid & user.cmdReady;
	assign dataAcc = user.dataInValid & user.dataInReady;
	assign reqAcc  = dram.reqValid & dram.reqReady;

	// --------------------
	// DRAM request
	assign dram.reqValid = ((state == S_RDMERGE) | (state == S_WRITE)) & ~sent;
	assign dram.reqCmd   = (state == S_WRITE) ? DRAM_WR : DRAM_RD;
	// Block address into the DRAM window
	assign dram.reqAddr  = `DRAM_BASE + {{(`DDRA_WIDTH - `ORAM_U){1'b0}}, addrR};
	// Merge already done here, whole beat goes out
	assign dram.reqWData = blockR;
	assign dram.reqWMask = {`DDRM_WIDTH{1'b1}};

	// Bytewise merge of new data over the old block
	always_comb begin
		for (int b = 0; b < `DM_WIDTH; b++) begin
			merged[8*b +: 8] = maskR[b] ? wDataR[8*b +: 8] : dram.rspData[8*b +: 8];
		end
	end

	// --------------------
	// Next state
	always_comb begin
		nextState = state;
		case (state)
			S_IDLE:
				if (cmdAcc)
					nextState = (user.cmd == CMD_READ) ? S_RDMERGE : S_COLLECT;
			S_COLLECT:
				// Full mask skips the read
				if (haveData)
					nextState = (&maskR) ? S_WRITE : S_RDMERGE;
			S_RDMERGE:
				if (sent && dram.rspValid)
					nextState = (cmdR == CMD_READ) ? S_RETURN : S_WRITE;
			S_WRITE:
				// Backend ready again once the beat is out
				if (sent && dram.reqReady)
					nextState = S_IDLE;
			S_RETURN:
				if (user.dataOutReady)
					nextState = S_IDLE;
			default:
				nextState = S_IDLE;
		endcase
	end

	// Control state
	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			state    <= S_IDLE;
			rdyR     <= 1'b0;
			haveData <= 1'b0;
			sent     <= 1'b0;
		end else begin
			state <= nextState;
			rdyR  <= (nextState == S_IDLE);
			if ((state == S_COLLECT) && (nextState != S_COLLECT))
				haveData <= 1'b0;
			else if (dataAcc)
				haveData <= 1'b1;
			if (nextState != state)
				sent <= 1'b0;
			else if (reqAcc)
				sent <= 1'b1;
		end
	end

	// --------------------
	// Payload
	always_ff @(posedge Clock) begin
		if (cmdAcc) begin
			cmdR  <= user.cmd;
			addrR <= user.pAddr;
			maskR <= user.wMask;
		end
		if (dataAcc)
			wDataR <= user.dataIn;
		if ((state == S_COLLECT) && (nextState == S_WRITE))
			blockR <= wDataR;
		else if ((state == S_RDMERGE) && sent && dram.rspValid)
			blockR <= (cmdR == CMD_READ) ? dram.rspData : merged;
	end

endmodule

// ==== verilog/trafficGen.sv ====
/*
 * Traffic generator, writes a known pattern then reads it back
 * Flags the first mismatch and holds it
 */
`timescale 1ns/1ps
`include "oram_config_config.svh"

module trafficGen (
	input  logic      Clock,
	input  logic      arstN,
	input  logic      enable,
	oramUserIf.master bus,
	output logic      done,
	output logic      error
);
	import oramPkg::*;

	typedef enum logic [2:0] {
		T_IDLE,
		T_WRITE,
		T_RCMD,
		T_RDATA,
		T_DONE
	} tgenState_t;

	localparam logic [`ORAM_U-1:0] LAST_ADDR = `ORAM_U'(`TGEN_COUNT - 1);

	tgenState_t          state;
	logic [`ORAM_U-1:0]  addr;
	// Write phase handshakes already done
	logic                cmdSent;
	logic                dataSent;
	logic                cmdAcc;
	logic                dataAcc;
	logic                rdAcc;
	logic                wrDone;

	assign cmdAcc  = bus.cmdValid & bus.cmdReady;
	assign dataAcc = bus.dataInValid & bus.dataInReady;
	assign rdAcc   = bus.dataOutValid & bus.dataOutReady;
	// Both halves of a write handed over
	assign wrDone  = (cmdSent | cmdAcc) & (dataSent | dataAcc);

	// --------------------
	// Bus drive
	assign bus.cmd          = (state == T_WRITE) ? CMD_WRITE : CMD_READ;
	assign bus.pAddr        = addr;
	assign bus.wMask        = {`DM_WIDTH{1'b1}};
	assign bus.cmdValid     = ((state == T_WRITE) & ~cmdSent) | (state == T_RCMD);
	assign bus.dataIn       = patternWord(addr);
	assign bus.dataInValid  = (state == T_WRITE) & ~dataSent;
	assign bus.dataOutReady = (state == T_RDATA);
	assign done             = (state == T_DONE);

	// --------------------
	// Sequencer
	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			state    <= T_IDLE;
			addr     <= '0;
			cmdSent  <= 1'b0;
			dataSent <= 1'b0;
			error    <= 1'b0;
		end else if (!enable) begin
			// Mode dropped, park
			state    <= T_IDLE;
			cmdSent  <= 1'b0;
			dataSent <= 1'b0;
		end else begin
			case (state)
				T_IDLE: begin
					state <= T_WRITE;
					addr  <= '0;
					// New run clears old result
					error <= 1'b0;
				end
				T_WRITE: begin
					if (wrDone) begin
						cmdSent  <= 1'b0;
						dataSent <= 1'b0;
						addr     <= (addr == LAST_ADDR) ? '0 : addr + 1'b1;
						if (addr == LAST_ADDR)
							state <= T_RCMD;
					end else begin
						cmdSent  <= cmdSent | cmdAcc;
						dataSent <= dataSent | dataAcc;
					end
				end
				T_RCMD: begin
					if (cmdAcc)
						state <= T_RDATA;
				end
				T_RDATA: begin
					if (rdAcc) begin
						// Sticky mismatch
						if (bus.dataOut != patternWord(addr))
							error <= 1'b1;
						addr  <= addr + 1'b1;
						state <= (addr == LAST_ADDR) ? T_DONE : T_RCMD;
					end
				end
				default: state <= T_DONE;
			endcase
		end
	end

endmodule

// ==== verilog/dramReqIf.sv ====
/*
 * Request bus from the controller core to the DRAM backend
 * One request at a time, read data comes back as a pulse
 */
`timescale 1ns/1ps
`include "oram_config_config.svh"

interface dramReqIf;
	import oramPkg::*;

	// --------------------
	// Request, valid/ready
	dramCmd_t                reqCmd;
	logic [`DDRA_WIDTH-1:0]  reqAddr;
	logic [`BED_WIDTH-1:0]   reqWData;
	// 1 writes the byte
	logic [`DDRM_WIDTH-1:0]  reqWMask;
	logic                    reqValid;
	logic                    reqReady;

	// --------------------
	// Read return, no back-pressure
	logic [`BED_WIDTH-1:0]   rspData;
	logic                    rspValid;

	modport core (
		output reqCmd, reqAddr, reqWData, reqWMask, reqValid,
		input  reqReady, rspData, rspValid
	);

	modport back (
		input  reqCmd, reqAddr, reqWData, reqWMask, reqValid,
		output reqReady, rspData, rspValid
	);

endinterface

// ==== verilog/oramUserIf.sv ====
/*
 * User side bus of the block memory controller
 * Command, write data and read data channels, valid/ready each
 */
`timescale 1ns/1ps
`include "oram_config_config.svh"

interface oramUserIf;
	import oramPkg::*;

	// --------------------
	// Command channel
	oramCmd_t               cmd;
	logic [`ORAM_U-1:0]     pAddr;
	// Byte enables, 1 writes the byte
	logic [`DM_WIDTH-1:0]   wMask;
	logic                   cmdValid;
	logic                   cmdReady;

	// --------------------
	// Write data channel
	logic [`FED_WIDTH-1:0]  dataIn;
	logic                   dataInValid;
	logic                   dataInReady;

	// --------------------
	// Read data channel
	logic [`FED_WIDTH-1:0]  dataOut;
	logic                   dataOutValid;
	logic                   dataOutReady;

	// Command source
	modport master (
		output cmd, pAddr, wMask, cmdValid, dataIn, dataInValid, dataOutReady,
		input  cmdReady, dataInReady, dataOut, dataOutValid
	);

	// Controller side
	modport slave (
		input  cmd, pAddr, wMask, cmdValid, dataIn, dataInValid, dataOutReady,
		output cmdReady, dataInReady, dataOut, dataOutValid
	);

endinterface

// ==== verilog/oramPkg.sv ====
/*
 * Shared types for the block memory controller
 * User and DRAM command encodings, test pattern rule
 */
`include "oram_config_config.svh"

package oramPkg;

	// User side commands
	typedef enum logic [1:0] {
		CMD_READ  = 2'd0,
		CMD_WRITE = 2'd1
	} oramCmd_t;

	// DRAM commands, DDR3 style encoding
	typedef enum logic [`DDRC_WIDTH-1:0] {
		DRAM_WR = 3'd0,
		DRAM_RD = 3'd1
	} dramCmd_t;

	// --------------------
	// Test pattern of one block
	// Address repeated over the word, then salted
	function automatic logic [`FED_WIDTH-1:0] patternWord(input logic [`ORAM_U-1:0] addr);
		logic [`FED_WIDTH-1:0] word;
		for (int i = 0; i < `FED_WIDTH; i++) begin
			word[i] = addr[i % `ORAM_U];
		end
		return word ^ `TGEN_SALT;
	endfunction

endpackage

// ==== include/oram_config_config.svh ====
/*
 * Block memory controller configuration
 * Widths, DRAM address map and traffic generator settings
 */
`ifndef ORAM_CONFIG_CONFIG_SVH
`define ORAM_CONFIG_CONFIG_SVH

// --------------------
// Data path widths
// Block address width
`define ORAM_U      12
// One user block per DRAM beat
`define FED_WIDTH   32
`define BED_WIDTH   32
`define DM_WIDTH    4
`define DDRM_WIDTH  4

// --------------------
// DRAM port
`define DDRA_WIDTH  16
`define DDRC_WIDTH  3
// Block 0 location in DRAM
`define DRAM_BASE   16'h1000
// Dummy traffic target
`define DUMMY_ADDR  16'h0000

// --------------------
// Traffic generator
`define TGEN_COUNT  64
`define TGEN_SALT   32'hA5C3_0F1E

`endif
